// ==== common/dot_matrix_pkg.sv ====
`default_nettype none

package dot_matrix_pkg;

    // scan timing kept short for simulation
    localparam int ROW_TICKS = 4;
    localparam int NUM_ROWS = 8;
    localparam int NUM_GLYPHS = 12; // this index and above are dark

    localparam int ROW_W = $clog2(NUM_ROWS);
    localparam int TICK_W = $clog2(ROW_TICKS);
    localparam int GLYPH_W = 4;

    localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(ROW_TICKS - 1);
    localparam logic [ROW_W-1:0] ROW_LAST = ROW_W'(NUM_ROWS - 1);

    // command opcodes
    typedef enum logic [1:0]
    {
        OP_SHOW  = 2'd0, // new glyph and unblank
        OP_COLOR = 2'd1,
        OP_BLANK = 2'd2  // glyph and color kept
    } disp_op_e;

    // bit 1 lights red and bit 0 lights green
    typedef enum logic [1:0]
    {
        COLOR_OFF   = 2'b00,
        COLOR_GREEN = 2'b01,
        COLOR_RED   = 2'b10,
        COLOR_AMBER = 2'b11
    } color_e;

    typedef struct packed
    {
        disp_op_e op;
        logic [GLYPH_W-1:0] glyph;
        color_e color;
    } disp_cmd_t;

    typedef struct packed
    {
        logic [GLYPH_W-1:0] glyph;
        color_e color;
        logic blank;
    } disp_state_t;

    typedef struct packed
    {
        logic [7:0] row;  // active low one-hot
        logic [7:0] colr; // active high
        logic [7:0] colg; // active high
    } matrix_drive_t;

    // power-up picture is blanked green blob 0
    localparam disp_state_t STATE_RESET = '{
        glyph: '0,
        color: COLOR_GREEN,
        blank: 1'b1
    };

endpackage

`default_nettype wire

// ==== hdl/glyph_rom.sv ====
`timescale 1ns/1ns
`default_nettype none

module glyph_rom
(
    input  logic [dot_matrix_pkg::GLYPH_W-1:0] glyph,
    input  logic [dot_matrix_pkg::ROW_W-1:0]   row_idx,
    output logic [7:0]                         bits
);

    always_comb
    begin
        bits = '0;
        if (glyph < dot_matrix_pkg::GLYPH_W'(dot_matrix_pkg::NUM_GLYPHS))
        begin
            case (glyph)
                // level blobs, smallest first
                4'd0: if (row_idx == 3'd3 || row_idx == 3'd4) bits = 8'b0001_1000;
                4'd1:
                case (row_idx)
                    3'd2, 3'd5: bits = 8'b0001_1000;
                    3'd3, 3'd4: bits = 8'b0011_1100;
                    default: bits = '0;
                endcase
                4'd2:
                case (row_idx)
                    3'd2, 3'd5: bits = 8'b0011_1100;
                    3'd3, 3'd4: bits = 8'b0111_1110;
                    default: bits = '0;
                endcase
                4'd3:
                case (row_idx)
                    3'd1, 3'd6: bits = 8'b0011_1100;
                    3'd0, 3'd7: bits = '0;
                    default: bits = 8'b0111_1110;
                endcase
                4'd4:
                case (row_idx)
                    3'd0, 3'd7: bits = 8'b0011_1100;
                    3'd1, 3'd6: bits = 8'b0111_1110;
                    default: bits = 8'b1111_1111;
                endcase
                4'd5: bits = 8'b1111_1111; // full block
                4'd6:
                case (row_idx) // heart
                    3'd1: bits = 8'b0110_0110;
                    3'd2, 3'd3: bits = 8'b1111_1111;
                    3'd4: bits = 8'b0111_1110;
                    3'd5: bits = 8'b0011_1100;
                    3'd6: bits = 8'b0001_1000;
                    default: bits = '0;
                endcase
                4'd7:
                case (row_idx) // smiley
                    3'd0, 3'd7: bits = 8'b0011_1100;
                    3'd1, 3'd6: bits = 8'b0100_0010;
                    3'd2, 3'd4: bits = 8'b1010_0101;
                    3'd3: bits = 8'b1000_0001;
                    default: bits = 8'b1001_1001;
                endcase
                4'd8:
                case (row_idx) // up arrow
                    3'd1: bits = 8'b0011_1100;
                    3'd2: bits = 8'b0111_1110;
                    3'd3: bits = 8'b1101_1011;
                    default: bits = 8'b0001_1000;
                endcase
                4'd9:
                case (row_idx) // check mark
                    3'd1: bits = 8'b0000_0001;
                    3'd2: bits = 8'b0000_0011;
                    3'd3: bits = 8'b0000_0110;
                    3'd4: bits = 8'b1000_1100;
                    3'd5: bits = 8'b1101_1000;
                    3'd6: bits = 8'b0111_0000;
                    3'd7: bits = 8'b0010_0000;
                    default: bits = '0;
                endcase
                4'd10:
                case (row_idx) // cross
                    3'd0, 3'd7: bits = 8'b1000_0001;
                    3'd1, 3'd6: bits = 8'b0100_0010;
                    3'd2, 3'd5: bits = 8'b0010_0100;
                    default: bits = 8'b0001_1000;
                endcase
                4'd11:
                case (row_idx) // thermometer
                    3'd0: bits = 8'b0001_1000;
                    3'd1, 3'd2: bits = 8'b0010_0100;
                    3'd3, 3'd4: bits = 8'b0010_1100;
                    3'd5, 3'd6: bits = 8'b0101_1110;
                    default: bits = 8'b0011_1100;
                endcase
                default: bits = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/pixel_driver.sv ====
`timescale 1ns/1ns
`default_nettype none

module pixel_driver
(
    input  logic                               clk,
    input  logic                               rst,
    input  logic [dot_matrix_pkg::ROW_W-1:0]   row_idx,
    input  dot_matrix_pkg::disp_state_t        state,
    output dot_matrix_pkg::matrix_drive_t      drive
);

    logic [7:0] rom_bits;
    logic red_on;
    logic green_on;

    glyph_rom rom_i
    (
        .glyph   (state.glyph),
        .row_idx (row_idx),
        .bits    (rom_bits)
    );

    // amber drives both planes
    assign red_on = !state.blank &&
        (state.color == dot_matrix_pkg::COLOR_RED ||
         state.color == dot_matrix_pkg::COLOR_AMBER);
    assign green_on = !state.blank &&
        (state.color == dot_matrix_pkg::COLOR_GREEN ||
         state.color == dot_matrix_pkg::COLOR_AMBER);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            drive.row <= '1; // all rows off
            drive.colr <= '0;
            drive.colg <= '0;
        end
        else
        begin
            drive.row <= ~(8'b0000_0001 << row_idx);
            drive.colr <= red_on ? rom_bits : 8'b0000_0000;
            drive.colg <= green_on ? rom_bits : 8'b0000_0000;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/row_scanner.sv ====
`timescale 1ns/1ns
`default_nettype none

module row_scanner
(
    input  logic                             clk,
    input  logic                             rst,
    output logic [dot_matrix_pkg::ROW_W-1:0] row_idx,
    output logic                             frame_start
);

    logic [dot_matrix_pkg::TICK_W-1:0] tick;
    logic row_step;

    assign row_step = (tick == dot_matrix_pkg::TICK_LAST);

    // last tick of row 7 where the row counter wraps
    assign frame_start = row_step && (row_idx == dot_matrix_pkg::ROW_LAST);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            tick <= '0;
        end
        else if (row_step)
        begin
            tick <= '0;
        end
        else
        begin
            tick <= tick + dot_matrix_pkg::TICK_W'(1);
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row_idx <= '0;
        end
        else if (row_step)
        begin
            if (row_idx == dot_matrix_pkg::ROW_LAST)
            begin
                row_idx <= '0;
            end
            else
            begin
                row_idx <= row_idx + dot_matrix_pkg::ROW_W'(1);
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/matrix_cmd_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

module matrix_cmd_decode
(
    input  logic                        clk,
    input  logic                        rst,
    input  dot_matrix_pkg::disp_cmd_t   cmd,
    input  logic                        cmd_valid,
    output logic                        cmd_ready,
    input  logic                        frame_start,
    output dot_matrix_pkg::disp_state_t state
);

    logic pend_full;
    logic take;
    dot_matrix_pkg::disp_cmd_t pend;

    // ready only while the one-entry slot is empty
    assign cmd_ready = ~pend_full;
    assign take = cmd_valid & cmd_ready;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            pend_full <= 1'b0;
        end
        else if (take)
        begin
            pend_full <= 1'b1;
        end
        else if (frame_start)
        begin
            pend_full <= 1'b0; // applied below on the same edge
        end
    end

    always_ff @(posedge clk)
    begin
        if (take)
        begin
            pend <= cmd;
        end
    end

    // active state only changes on a frame boundary
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state <= dot_matrix_pkg::STATE_RESET;
        end
        else if (frame_start && pend_full)
        begin
            case (pend.op)
                dot_matrix_pkg::OP_SHOW:
                begin
                    state.glyph <= pend.glyph;
                    state.blank <= 1'b0;
                end
                dot_matrix_pkg::OP_COLOR:
                begin
                    state.color <= pend.color;
                end
                dot_matrix_pkg::OP_BLANK:
                begin
                    state.blank <= 1'b1;
                end
                default:
                begin
                    state <= state; // reserved opcode is dropped
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/dot_matrix_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module dot_matrix_top
(
    input  logic                          clk,
    input  logic                          rst,
    input  dot_matrix_pkg::disp_cmd_t     cmd,
    input  logic                          cmd_valid,
    output logic                          cmd_ready,
    output dot_matrix_pkg::matrix_drive_t drive
);

    logic frame_start;
    logic [dot_matrix_pkg::ROW_W-1:0] row_idx;
    dot_matrix_pkg::disp_state_t state;

    matrix_cmd_decode decode_i
    (
        .clk         (clk),
        .rst         (rst),
        .cmd         (cmd),
        .cmd_valid   (cmd_valid),
        .cmd_ready   (cmd_ready),
        .frame_start (frame_start),
        .state       (state)
    );

    row_scanner scanner_i
    (
        .clk         (clk),
        .rst         (rst),
        .row_idx     (row_idx),
        .frame_start (frame_start)
    );

    // one clock behind row_idx and state
    pixel_driver driver_i
    (
        .clk     (clk),
        .rst     (rst),
        .row_idx (row_idx),
        .state   (state),
        .drive   (drive)
    );

endmodule

`default_nettype wire

// ==== dv/dot_matrix_asserts.sv ====
`timescale 1ns/1ns
`default_nettype none

module dot_matrix_asserts
(
    input logic                          clk,
    input logic                          rst,
    input dot_matrix_pkg::disp_cmd_t     cmd,
    input logic                          cmd_valid,
    input logic                          cmd_ready,
    input dot_matrix_pkg::matrix_drive_t drive
);

    logic scan_seen;
    int busy_cnt; // clocks with cmd_ready low in a row

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            scan_seen <= 1'b0;
            busy_cnt <= 0;
        end
        else
        begin
            scan_seen <= 1'b1;
            busy_cnt <= cmd_ready ? 0 : busy_cnt + 1;
        end
    end

    cmd_held: assert property (@(posedge clk) disable iff (rst)
        cmd_valid && !cmd_ready |=> $stable(cmd))
        else $error("cmd changed while waiting for cmd_ready");

    row_onehot: assert property (@(posedge clk) disable iff (rst)
        scan_seen |-> $onehot(~drive.row))
        else $error("drive.row does not have exactly one low bit");

    // one frame plus two clocks at most
    ready_back: assert property (@(posedge clk) disable iff (rst)
        busy_cnt <= dot_matrix_pkg::NUM_ROWS * dot_matrix_pkg::ROW_TICKS + 2)
        else $error("cmd_ready stayed low longer than a frame");

endmodule

bind dot_matrix_top dot_matrix_asserts asserts_i
(
    .clk       (clk),
    .rst       (rst),
    .cmd       (cmd),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .drive     (drive)
);

`default_nettype wire

// ==== dv/dot_matrix_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module dot_matrix_tb;

    localparam int CLK_PERIOD = 40;
    localparam int DIRECTED_CMDS = 24;
    localparam int RANDOM_CMDS = 40;
    localparam int NUM_CMDS = DIRECTED_CMDS + RANDOM_CMDS;
    localparam int FRAME_CLKS = dot_matrix_pkg::NUM_ROWS * dot_matrix_pkg::ROW_TICKS;
    localparam int WATCHDOG_NS = (NUM_CMDS + 2) * (FRAME_CLKS + 2) * CLK_PERIOD;

    logic clk = 1'b0;
    logic rst;
    dot_matrix_pkg::disp_cmd_t cmd;
    logic cmd_valid;
    logic cmd_ready;
    dot_matrix_pkg::matrix_drive_t drive;

    // reference model of scan position, pending slot and active state
    int m_tick;
    int m_row;
    logic m_pend_full;
    dot_matrix_pkg::disp_cmd_t m_pend;
    dot_matrix_pkg::disp_state_t m_state;

    logic fail_printed = 1'b0;
    logic run_done = 1'b0;

    dot_matrix_top dot_matrix_top_i
    (
        .clk       (clk),
        .rst       (rst),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .drive     (drive)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // row 0 in the top byte
    function automatic logic [7:0] model_glyph_row(input logic [3:0] g, input int r);
        logic [63:0] pic;
        case (g)
            4'd0: pic = 64'h0000_0018_1800_0000;
            4'd1: pic = 64'h0000_183C_3C18_0000;
            4'd2: pic = 64'h0000_3C7E_7E3C_0000;
            4'd3: pic = 64'h003C_7E7E_7E7E_3C00;
            4'd4: pic = 64'h3C7E_FFFF_FFFF_7E3C;
            4'd5: pic = 64'hFFFF_FFFF_FFFF_FFFF;
            4'd6: pic = 64'h0066_FFFF_7E3C_1800; // heart
            4'd7: pic = 64'h3C42_A581_A599_423C;
            4'd8: pic = 64'h183C_7EDB_1818_1818;
            4'd9: pic = 64'h0001_0306_8CD8_7020;
            4'd10: pic = 64'h8142_2418_1824_4281;
            4'd11: pic = 64'h1824_242C_2C5E_5E3C; // thermometer
            default: pic = '0;
        endcase
        return pic[8 * (7 - r) +: 8];
    endfunction

    function automatic dot_matrix_pkg::matrix_drive_t expected_drive(
        input int row,
        input dot_matrix_pkg::disp_state_t st
    );
        dot_matrix_pkg::matrix_drive_t d;
        logic [7:0] bits;
        bits = model_glyph_row(st.glyph, row);
        d.row = '1;
        d.row[row] = 1'b0; // only the current row pulled low
        d.colr = '0;
        d.colg = '0;
        if (!st.blank)
        begin
            case (st.color)
                dot_matrix_pkg::COLOR_RED: d.colr = bits;
                dot_matrix_pkg::COLOR_GREEN: d.colg = bits;
                dot_matrix_pkg::COLOR_AMBER:
                begin
                    d.colr = bits;
                    d.colg = bits;
                end
                default: d.colr = '0;
            endcase
        end
        return d;
    endfunction

    function automatic dot_matrix_pkg::color_e random_color();
        return dot_matrix_pkg::color_e'(2'($urandom_range(0, 3)));
    endfunction

    function automatic dot_matrix_pkg::disp_cmd_t make_cmd(
        input dot_matrix_pkg::disp_op_e op,
        input logic [3:0] glyph,
        input dot_matrix_pkg::color_e color
    );
        dot_matrix_pkg::disp_cmd_t c;
        c.op = op;
        c.glyph = glyph;
        c.color = color;
        return c;
    endfunction

    function automatic dot_matrix_pkg::disp_cmd_t random_cmd();
        dot_matrix_pkg::disp_op_e op;
        case ($urandom_range(0, 3))
            0, 1: op = dot_matrix_pkg::OP_SHOW;
            2: op = dot_matrix_pkg::OP_COLOR;
            default: op = dot_matrix_pkg::OP_BLANK;
        endcase
        return make_cmd(op, 4'($urandom_range(0, 15)), random_color());
    endfunction

    task automatic stop_on_error();
        fail_printed = 1'b1;
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_drive(
        input dot_matrix_pkg::matrix_drive_t expv,
        input dot_matrix_pkg::matrix_drive_t got
    );
        if (got !== expv)
        begin
            $display("Fail time=%0t signal=drive expected=%h got=%h", $time, expv, got);
            stop_on_error();
        end
    endtask

    task automatic check_ready(input logic expv, input logic got);
        if (got !== expv)
        begin
            $display("Fail time=%0t signal=cmd_ready expected=%b got=%b", $time, expv, got);
            stop_on_error();
        end
    endtask

    task automatic apply_cmd(input dot_matrix_pkg::disp_cmd_t c);
        case (c.op)
            dot_matrix_pkg::OP_SHOW:
            begin
                m_state.glyph = c.glyph;
                m_state.blank = 1'b0;
            end
            dot_matrix_pkg::OP_COLOR: m_state.color = c.color;
            dot_matrix_pkg::OP_BLANK: m_state.blank = 1'b1;
            default: m_state.blank = m_state.blank;
        endcase
    endtask

    // advance the model one clock and compare 5 ns after the edge
    task automatic step_cycle(output logic took);
        logic valid_pre;
        logic frame_edge;
        dot_matrix_pkg::disp_cmd_t cmd_pre;
        dot_matrix_pkg::matrix_drive_t exp_drive;
        valid_pre = cmd_valid;
        cmd_pre = cmd;
        @(posedge clk);
        #5;
        exp_drive = expected_drive(m_row, m_state); // drive lags by one clock
        frame_edge = (m_tick == dot_matrix_pkg::ROW_TICKS - 1) &&
            (m_row == dot_matrix_pkg::NUM_ROWS - 1);
        took = valid_pre && !m_pend_full;
        if (took)
        begin
            m_pend_full = 1'b1;
            m_pend = cmd_pre;
        end
        else if (frame_edge && m_pend_full)
        begin
            apply_cmd(m_pend); // seen from the next row-0 strobe
            m_pend_full = 1'b0;
        end
        if (m_tick == dot_matrix_pkg::ROW_TICKS - 1)
        begin
            m_tick = 0;
            m_row = (m_row + 1) % dot_matrix_pkg::NUM_ROWS;
        end
        else
        begin
            m_tick++;
        end
        check_drive(exp_drive, drive);
        check_ready(!m_pend_full, cmd_ready);
    endtask

    task automatic send_cmd(input dot_matrix_pkg::disp_cmd_t c);
        logic took;
        cmd = c;
        cmd_valid = 1'b1;
        took = 1'b0;
        while (!took)
        begin
            step_cycle(took);
        end
        cmd_valid = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        logic took;
        repeat (n)
        begin
            cmd = random_cmd(); // ignored while valid is low
            step_cycle(took);
        end
    endtask

    initial
    begin
        dot_matrix_pkg::matrix_drive_t exp_reset;
        void'($urandom(1217));
        rst = 1'b1;
        cmd = '0;
        cmd_valid = 1'b0;
        repeat (2) @(posedge clk);
        #5;
        exp_reset.row = '1;
        exp_reset.colr = '0;
        exp_reset.colg = '0;
        check_drive(exp_reset, drive);
        check_ready(1'b1, cmd_ready);
        rst = 1'b0;
        m_tick = 0;
        m_row = 0;
        m_pend_full = 1'b0;
        m_state.glyph = '0;
        m_state.color = dot_matrix_pkg::COLOR_GREEN;
        m_state.blank = 1'b1;

        // every glyph index including the dark ones
        for (int g = 0; g < 16; g++)
        begin
            send_cmd(make_cmd(dot_matrix_pkg::OP_SHOW, 4'(g), random_color()));
        end
        send_cmd(make_cmd(dot_matrix_pkg::OP_SHOW, 4'd7, random_color()));
        send_cmd(make_cmd(dot_matrix_pkg::OP_COLOR, 4'd3, dot_matrix_pkg::COLOR_RED));
        send_cmd(make_cmd(dot_matrix_pkg::OP_COLOR, 4'd9, dot_matrix_pkg::COLOR_AMBER));
        send_cmd(make_cmd(dot_matrix_pkg::OP_COLOR, 4'd1, dot_matrix_pkg::COLOR_OFF));
        send_cmd(make_cmd(dot_matrix_pkg::OP_COLOR, 4'd0, dot_matrix_pkg::COLOR_GREEN));
        send_cmd(make_cmd(dot_matrix_pkg::OP_BLANK, 4'd5, random_color()));
        send_cmd(make_cmd(dot_matrix_pkg::OP_COLOR, 4'd2, dot_matrix_pkg::COLOR_RED));
        send_cmd(make_cmd(dot_matrix_pkg::OP_SHOW, 4'd8, random_color()));

        for (int i = 0; i < RANDOM_CMDS; i++)
        begin
            idle_cycles(int'($urandom_range(0, 2)));
            send_cmd(random_cmd());
        end
        idle_cycles(2 * FRAME_CLKS + 2); // last command drawn for a whole frame

        run_done = 1'b1;
        $display("NO ERRORS");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("timeout: the command sequence did not finish within %0d ns", WATCHDOG_NS);
        stop_on_error();
    end

    final
    begin
        if (!run_done && !fail_printed)
        begin
            $display("ERRORS FOUND");
        end
    end

endmodule

`default_nettype wire

// ==== build.f ====
common/dot_matrix_pkg.sv
hdl/glyph_rom.sv
hdl/pixel_driver.sv
hdl/row_scanner.sv
hdl/matrix_cmd_decode.sv
hdl/dot_matrix_top.sv
dv/dot_matrix_asserts.sv
dv/dot_matrix_tb.sv

// ==== Makefile ====
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f build.f --top-module dot_matrix_tb -o dot_matrix_sim
	./obj_dir/dot_matrix_sim | tee $(LOG)
	@if grep -q "^NO ERRORS$$" $(LOG); then \
		echo "test passed"; \
	else \
		echo "test failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
